/* core_pkg.sv */
package core_pkg;

  ////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int DATA_W     = 32;
  localparam int INSTR_W    = 32;
  localparam int PC_W       = 8;
  localparam int DADDR_W    = 8;
  localparam int REG_IDX_W  = 5;
  localparam int IMM_W      = 16;
  localparam int OPCODE_W   = 6;
  localparam int NUM_REGS   = 32;
  localparam int IMEM_DEPTH = 256;
  localparam int DMEM_DEPTH = 256;

  // instruction fields
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_MSB  = 10;
  localparam int SHAMT_LSB  = 6;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [INSTR_W-1:0]   instr_t;
  typedef logic [PC_W-1:0]      pc_t;
  typedef logic [DADDR_W-1:0]   daddr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [IMM_W-1:0]     imm_t;

  typedef enum logic [OPCODE_W-1:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_sll  = 6'd7,
    op_addi = 6'd8,
    op_lw   = 6'd9,
    op_sw   = 6'd10,
    op_beq  = 6'd11,
    op_bne  = 6'd12,
    op_j    = 6'd13
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_exm,
    fwd_wb
  } fwd_sel_e;

endpackage

/* core_if.sv */
// decode/execute register contents
interface idex_if import core_pkg::*; ();
  logic     valid;
  alu_op_e  alu_op;
  logic     use_imm;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t dst;
  word_t    rs_data;
  word_t    rt_data;
  imm_t     imm;
  logic     reg_write;
  logic     mem_read;
  logic     mem_write;
  logic     branch_eq;
  logic     branch_ne;
  logic     jump;
  pc_t      target;

  modport producer (
    output valid, alu_op, use_imm, rs, rt, dst, rs_data, rt_data, imm,
           reg_write, mem_read, mem_write, branch_eq, branch_ne, jump, target
  );

  modport consumer (
    input valid, alu_op, use_imm, rs, rt, dst, rs_data, rt_data, imm,
          reg_write, mem_read, mem_write, branch_eq, branch_ne, jump, target
  );
endinterface

// execute/memory register contents
interface exm_if import core_pkg::*; ();
  logic     reg_write;
  logic     mem_read;
  logic     mem_write;
  reg_idx_t dst;
  word_t    alu_result;
  word_t    store_data;

  modport producer (output reg_write, mem_read, mem_write, dst, alu_result, store_data);
  modport consumer (input reg_write, mem_read, mem_write, dst, alu_result, store_data);
endinterface

/* fetch_unit.sv */
module fetch_unit import core_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   imem_write,
  input  pc_t    imem_addr,
  input  instr_t imem_data,
  input  logic   stall,
  input  logic   redirect,
  input  pc_t    redirect_pc,
  output logic   ifid_valid,
  output instr_t ifid_instr
);

  pc_t    pc;
  instr_t imem [IMEM_DEPTH];
  instr_t fetch_instr;

  ////////////////////////////////////////////////////////////
  // instruction memory
  ////////////////////////////////////////////////////////////

  // load port stays live through reset
  always_ff @(posedge clk) begin
    if (imem_write) begin
      imem[imem_addr] <= imem_data;
    end
  end

  assign fetch_instr = imem[pc];

  ////////////////////////////////////////////////////////////
  // program counter and fetch/decode register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= '0;
      ifid_valid <= 1'b0;
    end else if (redirect) begin
      // younger fetch is squashed
      pc         <= redirect_pc;
      ifid_valid <= 1'b0;
    end else if (!stall) begin
      pc         <= pc + pc_t'(1);
      ifid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ifid_instr <= fetch_instr;
    end
  end

endmodule

/* register_file.sv */
module register_file import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs,
  input  reg_idx_t rt,
  input  logic     wb_write,
  input  reg_idx_t wb_dst,
  input  word_t    wb_data,
  output word_t    rs_data,
  output word_t    rt_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write && wb_dst != '0) begin
      regs[wb_dst] <= wb_data;
    end
  end

  // write-through so decode sees the retiring value
  assign rs_data = (rs == '0) ? '0 :
                   (wb_write && wb_dst == rs) ? wb_data : regs[rs];
  assign rt_data = (rt == '0) ? '0 :
                   (wb_write && wb_dst == rt) ? wb_data : regs[rt];

endmodule

/* decode_unit.sv */
module decode_unit import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     ifid_valid,
  input  instr_t   ifid_instr,
  input  logic     wb_write,
  input  reg_idx_t wb_dst,
  input  word_t    wb_data,
  input  logic     redirect,
  output logic     stall,
  idex_if.producer idex
);

  opcode_e  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  imm_t     imm;
  word_t    rs_data;
  word_t    rt_data;

  alu_op_e  c_alu_op;
  logic     c_use_imm;
  logic     c_dst_rd;
  logic     c_reg_write;
  logic     c_mem_read;
  logic     c_mem_write;
  logic     c_branch_eq;
  logic     c_branch_ne;
  logic     c_jump;
  reg_idx_t dst;

  assign opcode = opcode_e'(ifid_instr[OPCODE_MSB:OPCODE_LSB]);
  assign rs     = ifid_instr[RS_MSB:RS_LSB];
  assign rt     = ifid_instr[RT_MSB:RT_LSB];
  assign rd     = ifid_instr[RD_MSB:RD_LSB];
  assign imm    = ifid_instr[IMM_MSB:IMM_LSB];

  register_file u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs       (rs),
    .rt       (rt),
    .wb_write (wb_write),
    .wb_dst   (wb_dst),
    .wb_data  (wb_data),
    .rs_data  (rs_data),
    .rt_data  (rt_data)
  );

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    c_alu_op    = alu_add;
    c_use_imm   = 1'b0;
    c_dst_rd    = 1'b0;
    c_reg_write = 1'b0;
    c_mem_read  = 1'b0;
    c_mem_write = 1'b0;
    c_branch_eq = 1'b0;
    c_branch_ne = 1'b0;
    c_jump      = 1'b0;
    case (opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll: begin
        c_dst_rd    = 1'b1;
        c_reg_write = 1'b1;
        case (opcode)
          op_sub:  c_alu_op = alu_sub;
          op_and:  c_alu_op = alu_and;
          op_or:   c_alu_op = alu_or;
          op_xor:  c_alu_op = alu_xor;
          op_slt:  c_alu_op = alu_slt;
          op_sll:  c_alu_op = alu_sll;
          default: c_alu_op = alu_add;
        endcase
      end
      op_addi: begin
        c_use_imm   = 1'b1;
        c_reg_write = 1'b1;
      end
      op_lw: begin
        c_use_imm   = 1'b1;
        c_reg_write = 1'b1;
        c_mem_read  = 1'b1;
      end
      op_sw: begin
        c_use_imm   = 1'b1;
        c_mem_write = 1'b1;
      end
      op_beq:  c_branch_eq = 1'b1;
      op_bne:  c_branch_ne = 1'b1;
      op_j:    c_jump      = 1'b1;
      default: c_jump      = 1'b0;
    endcase
  end

  assign dst = c_dst_rd ? rd : rt;

  // load in execute feeding this instruction
  assign stall = idex.valid && idex.mem_read && ifid_valid &&
                 (idex.dst == rs || idex.dst == rt);

  ////////////////////////////////////////////////////////////
  // decode/execute register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || redirect || stall || !ifid_valid) begin
      idex.valid     <= 1'b0;
      idex.reg_write <= 1'b0;
      idex.mem_read  <= 1'b0;
      idex.mem_write <= 1'b0;
      idex.branch_eq <= 1'b0;
      idex.branch_ne <= 1'b0;
      idex.jump      <= 1'b0;
    end else begin
      idex.valid     <= 1'b1;
      idex.reg_write <= c_reg_write && (dst != '0);
      idex.mem_read  <= c_mem_read;
      idex.mem_write <= c_mem_write;
      idex.branch_eq <= c_branch_eq;
      idex.branch_ne <= c_branch_ne;
      idex.jump      <= c_jump;
    end
  end

  always_ff @(posedge clk) begin
    idex.alu_op  <= c_alu_op;
    idex.use_imm <= c_use_imm;
    idex.rs      <= rs;
    idex.rt      <= rt;
    idex.dst     <= dst;
    idex.rs_data <= rs_data;
    idex.rt_data <= rt_data;
    idex.imm     <= imm;
    idex.target  <= imm[PC_W-1:0];
  end

endmodule

/* execute_unit.sv */
module execute_unit import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  idex_if.consumer idex,
  input  logic     wb_write,
  input  reg_idx_t wb_dst,
  input  word_t    wb_data,
  exm_if.producer  exm,
  output logic     redirect,
  output pc_t      redirect_pc
);

  fwd_sel_e           fwd_rs;
  fwd_sel_e           fwd_rt;
  word_t              rs_val;
  word_t              rt_val;
  word_t              op_b;
  word_t              imm_ext;
  logic [4:0]         shamt;
  word_t              alu_result;
  logic               rs_eq_rt;

  // newest producer wins and r0 never forwards
  function automatic fwd_sel_e fwd_select(input reg_idx_t src, input logic exm_wr,
                                          input reg_idx_t exm_idx, input logic wb_wr,
                                          input reg_idx_t wb_idx);
    fwd_sel_e sel;
    sel = fwd_none;
    if (src != '0) begin
      if (exm_wr && exm_idx == src) begin
        sel = fwd_exm;
      end else if (wb_wr && wb_idx == src) begin
        sel = fwd_wb;
      end
    end
    return sel;
  endfunction

  ////////////////////////////////////////////////////////////
  // operand forwarding
  ////////////////////////////////////////////////////////////

  assign fwd_rs = fwd_select(idex.rs, exm.reg_write, exm.dst, wb_write, wb_dst);
  assign fwd_rt = fwd_select(idex.rt, exm.reg_write, exm.dst, wb_write, wb_dst);

  always_comb begin
    case (fwd_rs)
      fwd_exm: rs_val = exm.alu_result;
      fwd_wb:  rs_val = wb_data;
      default: rs_val = idex.rs_data;
    endcase
    case (fwd_rt)
      fwd_exm: rt_val = exm.alu_result;
      fwd_wb:  rt_val = wb_data;
      default: rt_val = idex.rt_data;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////

  assign imm_ext = {{(DATA_W-IMM_W){1'b0}}, idex.imm};
  assign op_b    = idex.use_imm ? imm_ext : rt_val;
  assign shamt   = idex.imm[SHAMT_MSB:SHAMT_LSB];

  always_comb begin
    case (idex.alu_op)
      alu_sub: alu_result = rs_val - op_b;
      alu_and: alu_result = rs_val & op_b;
      alu_or:  alu_result = rs_val | op_b;
      alu_xor: alu_result = rs_val ^ op_b;
      alu_slt: alu_result = ($signed(rs_val) < $signed(op_b)) ? word_t'(1) : '0;
      // shifts the rt operand and ignores rs
      alu_sll: alu_result = op_b << shamt;
      default: alu_result = rs_val + op_b;
    endcase
  end

  // branch compare on forwarded values
  assign rs_eq_rt    = (rs_val == rt_val);
  assign redirect    = idex.valid && (idex.jump ||
                       (idex.branch_eq && rs_eq_rt) ||
                       (idex.branch_ne && !rs_eq_rt));
  assign redirect_pc = idex.target;

  ////////////////////////////////////////////////////////////
  // execute/memory register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !idex.valid) begin
      exm.reg_write <= 1'b0;
      exm.mem_read  <= 1'b0;
      exm.mem_write <= 1'b0;
    end else begin
      exm.reg_write <= idex.reg_write;
      exm.mem_read  <= idex.mem_read;
      exm.mem_write <= idex.mem_write;
    end
  end

  always_ff @(posedge clk) begin
    exm.dst        <= idex.dst;
    exm.alu_result <= alu_result;
    exm.store_data <= rt_val;
  end

endmodule

/* memory_unit.sv */
module memory_unit import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  exm_if.consumer  exm,
  output logic     wb_write,
  output reg_idx_t wb_dst,
  output word_t    wb_data
);

  word_t  dmem [DMEM_DEPTH];
  daddr_t addr;
  word_t  load_data;

  logic   wb_from_mem;
  word_t  wb_load_data;
  word_t  wb_alu_result;

  assign addr = exm.alu_result[DADDR_W-1:0];

  // word addressed, low bits of the alu result only
  always_ff @(posedge clk) begin
    if (exm.mem_write) begin
      dmem[addr] <= exm.store_data;
    end
  end

  assign load_data = dmem[addr];

  ////////////////////////////////////////////////////////////
  // memory/write-back register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_write    <= 1'b0;
      wb_from_mem <= 1'b0;
    end else begin
      wb_write    <= exm.reg_write;
      wb_from_mem <= exm.mem_read;
    end
  end

  always_ff @(posedge clk) begin
    wb_dst        <= exm.dst;
    wb_load_data  <= load_data;
    wb_alu_result <= exm.alu_result;
  end

  assign wb_data = wb_from_mem ? wb_load_data : wb_alu_result;

endmodule

/* pipelined_core.sv */
module pipelined_core import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     imem_write,
  input  pc_t      imem_addr,
  input  instr_t   imem_data,
  output logic     wb_valid,
  output reg_idx_t wb_reg,
  output word_t    wb_data
);

  logic     ifid_valid;
  instr_t   ifid_instr;
  logic     stall;
  logic     redirect;
  pc_t      redirect_pc;
  logic     wb_write;
  reg_idx_t wb_dst;

  idex_if idex ();
  exm_if  exm ();

  fetch_unit u_fetch (
    .clk         (clk),
    .reset       (reset),
    .imem_write  (imem_write),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ifid_valid  (ifid_valid),
    .ifid_instr  (ifid_instr)
  );

  decode_unit u_decode (
    .clk        (clk),
    .reset      (reset),
    .ifid_valid (ifid_valid),
    .ifid_instr (ifid_instr),
    .wb_write   (wb_write),
    .wb_dst     (wb_dst),
    .wb_data    (wb_data),
    .redirect   (redirect),
    .stall      (stall),
    .idex       (idex.producer)
  );

  execute_unit u_execute (
    .clk         (clk),
    .reset       (reset),
    .idex        (idex.consumer),
    .wb_write    (wb_write),
    .wb_dst      (wb_dst),
    .wb_data     (wb_data),
    .exm         (exm.producer),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  memory_unit u_memory (
    .clk      (clk),
    .reset    (reset),
    .exm      (exm.consumer),
    .wb_write (wb_write),
    .wb_dst   (wb_dst),
    .wb_data  (wb_data)
  );

  // one pulse per retiring register write
  assign wb_valid = wb_write;
  assign wb_reg   = wb_dst;

endmodule

/* pipelined_core_tb.sv */
module pipelined_core_tb import core_pkg::*; ();

  localparam int MAX_ROWS = 64;
  localparam int MAX_WB   = 256;

  logic     clk;
  logic     reset;
  logic     imem_write;
  pc_t      imem_addr;
  instr_t   imem_data;
  logic     wb_valid;
  reg_idx_t wb_reg;
  word_t    wb_data;

  // program table
  string  row_name [MAX_ROWS];
  instr_t row_instr [MAX_ROWS];
  int     num_rows = 0;

  // expected write-backs, in program order
  string    exp_name [MAX_WB];
  reg_idx_t exp_reg [MAX_WB];
  word_t    exp_val [MAX_WB];
  int       num_expected = 0;
  int       seen = 0;
  bit       reset_done = 1'b0;

  word_t       model_regs [NUM_REGS];
  logic [31:0] lfsr_state;

  pipelined_core uut (
    .clk        (clk),
    .reset      (reset),
    .imem_write (imem_write),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic instr_t reg_form(input opcode_e op, input reg_idx_t rd,
                                      input reg_idx_t rs, input reg_idx_t rt,
                                      input logic [4:0] sh);
    return {op, rs, rt, rd, sh, 6'd0};
  endfunction

  function automatic instr_t imm_form(input opcode_e op, input reg_idx_t rt,
                                      input reg_idx_t rs, input imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic add_row(input string name, input instr_t instr);
    row_name[num_rows]  = name;
    row_instr[num_rows] = instr;
    num_rows++;
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    // alu functions on two random operands
    random_bits(16, rnd);
    add_row("addi_rnd_a", imm_form(op_addi, 5'd1, 5'd0, imm_t'(rnd)));
    random_bits(16, rnd);
    add_row("addi_rnd_b", imm_form(op_addi, 5'd2, 5'd0, imm_t'(rnd)));
    add_row("add", reg_form(op_add, 5'd3, 5'd1, 5'd2, 5'd0));
    add_row("sub", reg_form(op_sub, 5'd4, 5'd1, 5'd2, 5'd0));
    add_row("and", reg_form(op_and, 5'd5, 5'd1, 5'd2, 5'd0));
    add_row("or", reg_form(op_or, 5'd6, 5'd1, 5'd2, 5'd0));
    add_row("xor", reg_form(op_xor, 5'd7, 5'd1, 5'd2, 5'd0));
    add_row("slt_ba", reg_form(op_slt, 5'd8, 5'd2, 5'd1, 5'd0));
    add_row("slt_ab", reg_form(op_slt, 5'd9, 5'd1, 5'd2, 5'd0));
    random_bits(5, rnd);
    add_row("sll", reg_form(op_sll, 5'd10, 5'd0, 5'd1, rnd[4:0]));
    random_bits(16, rnd);
    add_row("addi_fwd", imm_form(op_addi, 5'd11, 5'd3, imm_t'(rnd)));
    // dependency chain
    add_row("chain_base", imm_form(op_addi, 5'd12, 5'd0, 16'd5));
    add_row("fwd_exm", reg_form(op_add, 5'd13, 5'd12, 5'd12, 5'd0));
    add_row("fwd_exm_wb", reg_form(op_add, 5'd14, 5'd13, 5'd12, 5'd0));
    add_row("fwd_regfile", reg_form(op_sub, 5'd15, 5'd14, 5'd12, 5'd0));
    // memory and load-use
    add_row("addr_base", imm_form(op_addi, 5'd16, 5'd0, 16'd32));
    add_row("sw_fwd", imm_form(op_sw, 5'd15, 5'd16, 16'd4));
    add_row("lw_after_sw", imm_form(op_lw, 5'd17, 5'd16, 16'd4));
    add_row("load_use_rs", reg_form(op_add, 5'd18, 5'd17, 5'd1, 5'd0));
    add_row("sw_second", imm_form(op_sw, 5'd18, 5'd16, 16'd5));
    add_row("lw_second", imm_form(op_lw, 5'd19, 5'd16, 16'd5));
    random_bits(16, rnd);
    add_row("load_use_imm", imm_form(op_addi, 5'd20, 5'd19, imm_t'(rnd)));
    // control flow
    add_row("br_val", imm_form(op_addi, 5'd21, 5'd0, 16'd7));
    add_row("beq_taken", imm_form(op_beq, 5'd21, 5'd21, 16'd26));
    add_row("flushed_a", imm_form(op_addi, 5'd22, 5'd0, 16'd1));
    add_row("flushed_b", imm_form(op_addi, 5'd23, 5'd0, 16'd2));
    add_row("bne_not_taken", imm_form(op_bne, 5'd21, 5'd21, 16'd24));
    add_row("after_bne", imm_form(op_addi, 5'd24, 5'd0, 16'd3));
    add_row("jump", imm_form(op_j, 5'd0, 5'd0, 16'd31));
    add_row("flushed_c", imm_form(op_addi, 5'd25, 5'd0, 16'd4));
    add_row("flushed_d", imm_form(op_addi, 5'd26, 5'd0, 16'd5));
    add_row("after_jump", imm_form(op_addi, 5'd27, 5'd21, 16'd1));
    // register zero
    random_bits(16, rnd);
    add_row("write_r0", imm_form(op_addi, 5'd0, 5'd1, imm_t'(rnd)));
    add_row("read_r0_fwd", reg_form(op_add, 5'd28, 5'd0, 5'd1, 5'd0));
    add_row("read_r0_zero", reg_form(op_or, 5'd29, 5'd0, 5'd0, 5'd0));
    // spin here once the program is done
    add_row("halt", imm_form(op_j, 5'd0, 5'd0, 16'(num_rows)));
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  task automatic expect_write(input string name, input reg_idx_t dst, input word_t value);
    if (dst != '0) begin
      model_regs[dst]         = value;
      exp_name[num_expected]  = name;
      exp_reg[num_expected]   = dst;
      exp_val[num_expected]   = value;
      num_expected++;
    end
  endtask

  // sequential walk, one instruction at a time
  task automatic run_model();
    word_t    mem_m [DMEM_DEPTH];
    instr_t   ins;
    opcode_e  op;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    logic [4:0] sh;
    word_t    a;
    word_t    b;
    word_t    imm_w;
    daddr_t   ma;
    int       pc;
    int       next_pc;
    int       steps;
    logic     done;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 1000 && pc < num_rows) begin
      ins     = row_instr[pc];
      op      = opcode_e'(ins[OPCODE_MSB:OPCODE_LSB]);
      rs      = ins[RS_MSB:RS_LSB];
      rt      = ins[RT_MSB:RT_LSB];
      rd      = ins[RD_MSB:RD_LSB];
      sh      = ins[SHAMT_MSB:SHAMT_LSB];
      a       = model_regs[rs];
      b       = model_regs[rt];
      imm_w   = {16'd0, ins[IMM_MSB:IMM_LSB]};
      ma      = daddr_t'(a + imm_w);
      next_pc = pc + 1;
      case (op)
        op_add:  expect_write(row_name[pc], rd, a + b);
        op_sub:  expect_write(row_name[pc], rd, a - b);
        op_and:  expect_write(row_name[pc], rd, a & b);
        op_or:   expect_write(row_name[pc], rd, a | b);
        op_xor:  expect_write(row_name[pc], rd, a ^ b);
        op_slt:  expect_write(row_name[pc], rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        op_sll:  expect_write(row_name[pc], rd, b << sh);
        op_addi: expect_write(row_name[pc], rt, a + imm_w);
        op_lw:   expect_write(row_name[pc], rt, mem_m[ma]);
        op_sw:   mem_m[ma] = b;
        op_beq:  if (a == b) next_pc = int'(ins[7:0]);
        op_bne:  if (a != b) next_pc = int'(ins[7:0]);
        op_j: begin
          if (int'(ins[7:0]) == pc) begin
            done = 1'b1;
          end
          next_pc = int'(ins[7:0]);
        end
        default: next_pc = pc + 1;
      endcase
      pc = next_pc;
      steps++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_equal(input string test, input string what,
                             input word_t expected, input word_t actual);
    if (expected !== actual) begin
      abort_run($sformatf("MISMATCH %s %s expected %08h actual %08h",
                          test, what, expected, actual));
    end
  endtask

  // outputs settle after the rising edge
  always @(negedge clk) begin
    if (wb_valid === 1'b1) begin
      if (seen >= num_expected) begin
        abort_run($sformatf("unexpected write-back to r%0d after all expected ones",
                            wb_reg));
      end else begin
        check_equal(exp_name[seen], "reg", word_t'(exp_reg[seen]), word_t'(wb_reg));
        check_equal(exp_name[seen], "data", exp_val[seen], wb_data);
        seen++;
      end
    end
  end

  initial begin
    wait (reset_done);
    repeat (10 * num_rows + 50) @(posedge clk);
    abort_run($sformatf("timeout, %0d of %0d expected write-backs are missing",
                        num_expected - seen, num_expected));
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    imem_write = 1'b0;
    imem_addr  = '0;
    imem_data  = '0;
    lfsr_state = 32'd76506;
    build_program();
    run_model();
    // reset covers the load and three more cycles
    for (int i = 0; i < num_rows; i++) begin
      @(negedge clk);
      imem_write = 1'b1;
      imem_addr  = pc_t'(i);
      imem_data  = row_instr[i];
    end
    @(negedge clk);
    imem_write = 1'b0;
    repeat (3) @(negedge clk);
    reset      = 1'b0;
    reset_done = 1'b1;
    wait (seen == num_expected);
    // late extra write-backs still get caught
    repeat (20) @(negedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

/* pipelined_core.f */
core_pkg.sv
core_if.sv
fetch_unit.sv
register_file.sv
decode_unit.sv
execute_unit.sv
memory_unit.sv
pipelined_core.sv
pipelined_core_tb.sv

/* Bender.yml */
package:
  name: pipelined_core

sources:
  - core_pkg.sv
  - core_if.sv
  - fetch_unit.sv
  - register_file.sv
  - decode_unit.sv
  - execute_unit.sv
  - memory_unit.sv
  - pipelined_core.sv
  - target: test
    files:
      - pipelined_core_tb.sv
